//--- i3c_target_vectors.txt
# sta dyn sta_v dyn_v addr_byte end(0 stop,1 sr) nbytes d0 d1 d2 d3 bad_mask full_idx(f none)
# ack nexp e0 e1 e2 e3 desc   (all hex, one transfer per line)
2a 00 1 0 54 0 4 11 22 33 44 0 f 1 4 11 22 33 44 002a0004
2a 35 1 1 54 0 0 00 00 00 00 0 f 0 0 00 00 00 00 00000000
2a 35 1 1 6a 0 3 a5 5a 3c 00 0 f 1 3 a5 5a 3c 00 00350003
2a 00 1 0 55 0 0 00 00 00 00 0 f 0 0 00 00 00 00 00000000
2a 00 1 0 40 0 0 00 00 00 00 0 f 0 0 00 00 00 00 00000000
2a 00 1 0 54 0 3 01 02 03 00 2 f 1 2 01 03 00 00 402a0002
2a 00 1 0 54 0 4 10 20 30 40 0 2 1 3 10 20 40 00 202a0003
2a 00 1 0 54 1 2 77 88 00 00 0 f 1 2 77 88 00 00 002a0002
2a 00 1 0 54 0 1 99 00 00 00 0 f 1 1 99 00 00 00 002a0001

//--- list.f
+incdir+.
i3c_target_pkg.sv
bus_monitor.sv
bus_rx_sampler.sv
target_rx_fsm.sv
i3c_target_rx.sv
tb_i3c_target_rx.sv

//--- Bender.yml
package:
  name: i3c_target_rx

sources:
  - files:
      - i3c_target_pkg.sv
      - bus_monitor.sv
      - bus_rx_sampler.sv
      - target_rx_fsm.sv
      - i3c_target_rx.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_i3c_target_rx.sv

//--- i3c_bus_driver.svh
// I3C controller model: drives SCL and SDA as an open-drain bus master for the testbench
`ifndef I3C_BUS_DRIVER_SVH
`define I3C_BUS_DRIVER_SVH

// Advance n clocks and land just after the rising edge
task automatic wait_clks(input int n);
  repeat (n) @(posedge clk_i);
  #DriveDelay;
endtask

// SCL low phase with a random stretch, SDA changes halfway through
task automatic low_phase(input logic sda_val);
  int lo;
  lo = $urandom_range(SclLowMax, SclLowMin);
  wait_clks(lo / 2);
  sda_drv = sda_val;
  wait_clks(lo - lo / 2);
endtask

// SCL high phase, bus level sampled in the middle
task automatic scl_pulse(output logic sda_seen);
  scl_drv = 1'b1;
  wait_clks(SclHigh / 2);
  sda_seen = sda_line;
  wait_clks(SclHigh / 2);
  scl_drv = 1'b0;
endtask

task automatic send_bit(input logic b, output logic sda_seen);
  low_phase(b);
  scl_pulse(sda_seen);
endtask

// MSB first
task automatic send_byte(input logic [7:0] b);
  logic seen;
  for (int i = 7; i >= 0; i--) begin
    send_bit(b[i], seen);
  end
endtask

// SDA released so that the target can pull it low
task automatic ack_phase(output logic acked);
  logic seen;
  send_bit(1'b1, seen);
  acked = !seen;
endtask

task automatic start_cond();
  wait_clks(SclHigh);
  sda_drv = 1'b0;
  wait_clks(SclHigh / 2);
  scl_drv = 1'b0;
endtask

task automatic rstart_cond();
  low_phase(1'b1);
  scl_drv = 1'b1;
  wait_clks(SclHigh / 2);
  sda_drv = 1'b0;
  wait_clks(SclHigh / 2);
  scl_drv = 1'b0;
endtask

// Leaves both lines high
task automatic stop_cond();
  low_phase(1'b0);
  scl_drv = 1'b1;
  wait_clks(SclHigh / 2);
  sda_drv = 1'b1;
  wait_clks(SclHigh);
endtask

`endif

//--- tb_i3c_target_rx.sv
// Testbench for the I3C target receive path, driven by transfers from a vector file
module tb_i3c_target_rx
  import i3c_target_pkg::*;
();

  localparam int ClkPeriod    = 40;
  localparam int DriveDelay   = 2;
  localparam int SclHigh      = 8;
  localparam int SclLowMin    = 8;
  localparam int SclLowMax    = 11;
  localparam int SclPerVector = 64;
  localparam int DescWaitClks = 16;
  localparam int unsigned Seed = 32'h9d74;

  typedef struct packed {
    logic [AddrWidth-1:0]      sta_addr;
    logic [AddrWidth-1:0]      dyn_addr;
    logic                      sta_valid;
    logic                      dyn_valid;
    logic [DataWidth-1:0]      addr;
    logic                      end_sr;
    logic [2:0]                nbytes;
    logic [3:0][DataWidth-1:0] data;
    logic [3:0]                bad_mask;
    logic [3:0]                full_idx;
    logic                      ack;
    logic [2:0]                nexp;
    logic [3:0][DataWidth-1:0] exp_data;
    logic [DescWidth-1:0]      desc;
  } vector_t;

  logic clk_i;
  logic rst_ni;
  logic scl_drv;
  logic sda_drv;
  logic sda_line;
  logic [AddrWidth-1:0] sta_addr;
  logic [AddrWidth-1:0] dyn_addr;
  logic sta_valid;
  logic dyn_valid;
  logic target_en;
  logic queue_full;
  logic sda_out;
  logic rx_wvalid;
  logic [DataWidth-1:0] rx_wdata;
  logic desc_wvalid;
  logic [DescWidth-1:0] desc_wdata;
  logic [DataWidth-1:0] bus_addr;
  logic bus_addr_valid;
  logic parity_err;

  vector_t vecs[$];
  logic [DataWidth-1:0] got_bytes[$];
  logic [DescWidth-1:0] got_descs[$];
  logic [DataWidth-1:0] seen_addr;
  logic addr_seen;
  logic bus_open;
  int parity_cnt;
  int num_vecs;
  int failed_tests;
  int load_errors;

  // Open-drain wired AND of controller and target
  assign sda_line = sda_drv & sda_out;

  `include "i3c_bus_driver.svh"

  i3c_target_rx #(
    .SyncStages(2)
  ) dut (
    .clk_i,
    .rst_ni,
    .scl_i                  (scl_drv),
    .sda_i                  (sda_line),
    .target_sta_addr_i      (sta_addr),
    .target_dyn_addr_i      (dyn_addr),
    .target_sta_addr_valid_i(sta_valid),
    .target_dyn_addr_valid_i(dyn_valid),
    .target_en_i            (target_en),
    .rx_queue_full_i        (queue_full),
    .sda_o                  (sda_out),
    .rx_queue_wvalid_o      (rx_wvalid),
    .rx_queue_wdata_o       (rx_wdata),
    .rx_desc_wvalid_o       (desc_wvalid),
    .rx_desc_wdata_o        (desc_wdata),
    .bus_addr_o             (bus_addr),
    .bus_addr_valid_o       (bus_addr_valid),
    .parity_err_o           (parity_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (rx_wvalid) got_bytes.push_back(rx_wdata);
    if (desc_wvalid) got_descs.push_back(desc_wdata);
    if (parity_err) parity_cnt++;
    if (bus_addr_valid) begin
      addr_seen = 1'b1;
      seen_addr = bus_addr;
    end
  end

  initial begin
    longint limit;
    wait (num_vecs > 0);
    limit = longint'(num_vecs) * SclPerVector * (SclHigh + SclLowMax) * ClkPeriod;
    #(limit);
    $display("timeout: the run did not end within %0d time units", limit);
    $display("Test failed");
    $finish;
  end

  task automatic read_vectors();
    int fd;
    int n;
    string line;
    logic [31:0] f [20];
    vector_t v;
    fd = $fopen("i3c_target_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file i3c_target_vectors.txt");
      load_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                      f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
          if (n != 20) begin
            $display("malformed vector line: %s", line);
            load_errors++;
          end else begin
            v.sta_addr  = f[0][AddrWidth-1:0];
            v.dyn_addr  = f[1][AddrWidth-1:0];
            v.sta_valid = f[2][0];
            v.dyn_valid = f[3][0];
            v.addr      = f[4][DataWidth-1:0];
            v.end_sr    = f[5][0];
            v.nbytes    = f[6][2:0];
            for (int i = 0; i < 4; i++) begin
              v.data[i]     = f[7+i][DataWidth-1:0];
              v.exp_data[i] = f[15+i][DataWidth-1:0];
            end
            v.bad_mask = f[11][3:0];
            v.full_idx = f[12][3:0];
            v.ack      = f[13][0];
            v.nexp     = f[14][2:0];
            v.desc     = f[19];
            vecs.push_back(v);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input vector_t v, input int idx);
    logic acked;
    logic seen;
    int errs;
    int exp_par;
    int waited;
    errs = 0;
    exp_par = 0;
    waited = 0;
    sta_addr  = v.sta_addr;
    dyn_addr  = v.dyn_addr;
    sta_valid = v.sta_valid;
    dyn_valid = v.dyn_valid;
    got_bytes.delete();
    got_descs.delete();
    parity_cnt = 0;
    addr_seen  = 1'b0;
    // After an Sr the bus is still open
    if (!bus_open) start_cond();
    send_byte(v.addr);
    ack_phase(acked);
    if (acked) begin
      for (int i = 0; i < v.nbytes; i++) begin
        queue_full = (v.full_idx == i);
        send_byte(v.data[i]);
        // Odd parity over nine bits unless the mask asks for a bad T-bit
        send_bit(~(^v.data[i]) ^ v.bad_mask[i], seen);
        queue_full = 1'b0;
        if (v.bad_mask[i]) exp_par++;
      end
    end
    if (v.end_sr) begin
      rstart_cond();
      bus_open = 1'b1;
    end else begin
      stop_cond();
      bus_open = 1'b0;
    end
    if (v.ack) begin
      while (got_descs.size() == 0 && waited < DescWaitClks) begin
        wait_clks(1);
        waited++;
      end
    end else begin
      wait_clks(DescWaitClks);
    end

    if (acked !== v.ack) begin
      $display("MISMATCH test %0d ack: got %h expected %h", idx, acked, v.ack);
      errs++;
    end
    if (!addr_seen) begin
      $display("test %0d: bus_addr_valid_o never pulsed for the address byte", idx);
      errs++;
    end else if (seen_addr !== v.addr) begin
      $display("MISMATCH test %0d bus_addr_o: got %h expected %h", idx, seen_addr, v.addr);
      errs++;
    end
    if (got_bytes.size() != v.nexp) begin
      $display("test %0d: %0d bytes written to the RX queue instead of %0d",
               idx, got_bytes.size(), v.nexp);
      errs++;
    end else begin
      foreach (got_bytes[i]) begin
        if (got_bytes[i] !== v.exp_data[i]) begin
          $display("MISMATCH test %0d rx_queue_wdata_o: got %h expected %h",
                   idx, got_bytes[i], v.exp_data[i]);
          errs++;
        end
      end
    end
    if (parity_cnt != exp_par) begin
      $display("test %0d: parity_err_o pulsed %0d times instead of %0d", idx, parity_cnt, exp_par);
      errs++;
    end
    if (v.ack && got_descs.size() != 1) begin
      $display("test %0d: %0d descriptors written instead of one", idx, got_descs.size());
      errs++;
    end else if (v.ack && got_descs[0] !== v.desc) begin
      $display("MISMATCH test %0d rx_desc_wdata_o: got %h expected %h", idx, got_descs[0], v.desc);
      errs++;
    end else if (!v.ack && got_descs.size() != 0) begin
      $display("test %0d: a descriptor was written for a NACKed transfer", idx);
      errs++;
    end
    if (errs != 0) failed_tests++;
    $display("test %0d (address byte %h): %s", idx, v.addr, errs == 0 ? "passed" : "FAILED");
  endtask

  initial begin
    int unsigned rnd_init;
    rnd_init   = $urandom(Seed);
    rst_ni     = 1'b0;
    scl_drv    = 1'b1;
    sda_drv    = 1'b1;
    sta_addr   = '0;
    dyn_addr   = '0;
    sta_valid  = 1'b0;
    dyn_valid  = 1'b0;
    target_en  = 1'b1;
    queue_full = 1'b0;
    bus_open   = 1'b0;
    read_vectors();
    num_vecs = vecs.size();
    if (num_vecs == 0) begin
      $display("no usable transfers in the vector file");
      load_errors++;
    end
    repeat (3) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;
    wait_clks(4);
    foreach (vecs[i]) run_test(vecs[i], i);
    $display("%0d tests run, %0d passed, %0d failed, %0d vector file errors",
             num_vecs, num_vecs - failed_tests, failed_tests, load_errors);
    if (failed_tests == 0 && load_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- i3c_target_rx.sv
// I3C target receive path top: bus monitor, bit sampler and target write FSM
module i3c_target_rx
  import i3c_target_pkg::*;
#(
  parameter int unsigned SyncStages = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 scl_i,
  input  logic                 sda_i,
  input  logic [AddrWidth-1:0] target_sta_addr_i,
  input  logic [AddrWidth-1:0] target_dyn_addr_i,
  input  logic                 target_sta_addr_valid_i,
  input  logic                 target_dyn_addr_valid_i,
  input  logic                 target_en_i,
  input  logic                 rx_queue_full_i,
  output logic                 sda_o,
  output logic                 rx_queue_wvalid_o,
  output logic [DataWidth-1:0] rx_queue_wdata_o,
  output logic                 rx_desc_wvalid_o,
  output logic [DescWidth-1:0] rx_desc_wdata_o,
  output logic [DataWidth-1:0] bus_addr_o,
  output logic                 bus_addr_valid_o,
  output logic                 parity_err_o
);

  bus_event_t bus_event;
  rx_sample_t rx_sample;

  bus_monitor #(
    .SyncStages(SyncStages)
  ) u_bus_monitor (
    .clk_i,
    .rst_ni,
    .scl_i,
    .sda_i,
    .bus_event_o(bus_event)
  );

  bus_rx_sampler u_bus_rx_sampler (
    .clk_i,
    .rst_ni,
    .bus_event_i(bus_event),
    .rx_sample_o(rx_sample)
  );

  target_rx_fsm u_target_rx_fsm (
    .clk_i,
    .rst_ni,
    .bus_event_i(bus_event),
    .rx_sample_i(rx_sample),
    .target_sta_addr_i,
    .target_dyn_addr_i,
    .target_sta_addr_valid_i,
    .target_dyn_addr_valid_i,
    .target_en_i,
    .rx_queue_full_i,
    .sda_o,
    .rx_queue_wvalid_o,
    .rx_queue_wdata_o,
    .rx_desc_wvalid_o,
    .rx_desc_wdata_o,
    .bus_addr_o,
    .bus_addr_valid_o,
    .parity_err_o
  );

endmodule

//--- target_rx_fsm.sv
// I3C target write FSM: address match, ACK, T-bit check and RX queue/descriptor writes
module target_rx_fsm
  import i3c_target_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  bus_event_t           bus_event_i,
  input  rx_sample_t           rx_sample_i,
  input  logic [AddrWidth-1:0] target_sta_addr_i,
  input  logic [AddrWidth-1:0] target_dyn_addr_i,
  input  logic                 target_sta_addr_valid_i,
  input  logic                 target_dyn_addr_valid_i,
  input  logic                 target_en_i,
  input  logic                 rx_queue_full_i,
  output logic                 sda_o,
  output logic                 rx_queue_wvalid_o,
  output logic [DataWidth-1:0] rx_queue_wdata_o,
  output logic                 rx_desc_wvalid_o,
  output logic [DescWidth-1:0] rx_desc_wdata_o,
  output logic [DataWidth-1:0] bus_addr_o,
  output logic                 bus_addr_valid_o,
  output logic                 parity_err_o
);

  target_state_e state_q;

  logic [DescCountMsb-DescCountLsb:0] count_q;
  logic ovfl_q;
  logic parity_q;
  logic [DataWidth-1:0] data_q;

  logic [AddrWidth-1:0] rx_addr;
  logic rx_rnw;
  logic addr_match;
  logic t_bit_ok;
  logic xfer_end;
  logic [DescWidth-1:0] desc;

  assign rx_addr = rx_sample_i.data[DataWidth-1:1];
  assign rx_rnw  = rx_sample_i.data[0];

  // Dynamic address takes over from the static one once assigned
  assign addr_match = target_en_i && !rx_rnw &&
                      (target_dyn_addr_valid_i ? (rx_addr == target_dyn_addr_i) :
                       (target_sta_addr_valid_i && (rx_addr == target_sta_addr_i)));

  // Data byte plus T-bit must hold an odd number of ones
  assign t_bit_ok = ^{data_q, rx_sample_i.bit9};

  assign xfer_end = bus_event_i.start || bus_event_i.rstart || bus_event_i.stop;

  always_comb begin
    desc = '0;
    desc[DescCountMsb:DescCountLsb] = count_q;
    desc[DescAddrLsb +: AddrWidth]  = bus_addr_o[DataWidth-1:1];
    desc[DescOvflBit]               = ovfl_q;
    desc[DescParityBit]             = parity_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q           <= Idle;
      sda_o             <= 1'b1;
      rx_queue_wvalid_o <= 1'b0;
      rx_desc_wvalid_o  <= 1'b0;
      bus_addr_o        <= '0;
      bus_addr_valid_o  <= 1'b0;
      parity_err_o      <= 1'b0;
      count_q           <= '0;
      ovfl_q            <= 1'b0;
      parity_q          <= 1'b0;
    end else begin
      rx_queue_wvalid_o <= 1'b0;
      rx_desc_wvalid_o  <= 1'b0;
      bus_addr_valid_o  <= 1'b0;
      parity_err_o      <= 1'b0;
      if (xfer_end) begin
        // Only a write transfer gets a descriptor
        rx_desc_wvalid_o <= (state_q == Write);
        sda_o            <= 1'b1;
        state_q          <= bus_event_i.stop ? Idle : Addr;
      end else begin
        unique case (state_q)
          Addr: begin
            if (rx_sample_i.byte_valid) begin
              bus_addr_o       <= rx_sample_i.data;
              bus_addr_valid_o <= 1'b1;
              if (addr_match) begin
                state_q  <= Ack;
                count_q  <= '0;
                ovfl_q   <= 1'b0;
                parity_q <= 1'b0;
              end else begin
                state_q <= Skip;
              end
            end
          end
          Ack: begin
            // Pull low on the negedge after bit 8, release after bit 9
            if (bus_event_i.scl_negedge) begin
              if (sda_o) begin
                sda_o <= 1'b0;
              end else begin
                sda_o   <= 1'b1;
                state_q <= Write;
              end
            end
          end
          Write: begin
            if (rx_sample_i.bit9_valid) begin
              if (!t_bit_ok) begin
                parity_err_o <= 1'b1;
                parity_q     <= 1'b1;
              end else if (rx_queue_full_i) begin
                ovfl_q <= 1'b1;
              end else begin
                rx_queue_wvalid_o <= 1'b1;
                count_q           <= count_q + 1'b1;
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == Write && rx_sample_i.byte_valid) begin
      data_q <= rx_sample_i.data;
    end
    if (state_q == Write && rx_sample_i.bit9_valid) begin
      rx_queue_wdata_o <= data_q;
    end
    if (xfer_end) begin
      rx_desc_wdata_o <= desc;
    end
  end

  ack_only_in_ack_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !sda_o |-> (state_q == Ack));

  // Queue write decided in a cycle where the queue had room
  no_write_when_full_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_queue_wvalid_o |-> !$past(rx_queue_full_i));

endmodule

//--- bus_rx_sampler.sv
// I3C bit sampler: shifts SDA in on SCL rising edges and reports each byte and ninth bit
module bus_rx_sampler
  import i3c_target_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  bus_event_t bus_event_i,
  output rx_sample_t rx_sample_o
);

  localparam int unsigned CntWidth = $clog2(DataWidth + 1);

  logic [CntWidth-1:0]  bit_cnt_q;
  logic [DataWidth-2:0] shift_q;
  logic                 last_data_bit;
  logic                 ninth_bit;

  assign last_data_bit = (bit_cnt_q == CntWidth'(DataWidth - 1));
  assign ninth_bit     = (bit_cnt_q == CntWidth'(DataWidth));

  // Bit counter runs 0..8 and restarts at every START or Sr
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt_q <= '0;
    end else if (bus_event_i.start || bus_event_i.rstart) begin
      bit_cnt_q <= '0;
    end else if (bus_event_i.scl_posedge) begin
      if (ninth_bit) begin
        bit_cnt_q <= '0;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end
  end

  // MSB first
  always_ff @(posedge clk_i) begin
    if (bus_event_i.scl_posedge) begin
      shift_q <= {shift_q[DataWidth-3:0], bus_event_i.sda};
    end
  end

  // Byte completes with the bit being sampled right now
  always_comb begin
    rx_sample_o.byte_valid = bus_event_i.scl_posedge & last_data_bit;
    rx_sample_o.bit9_valid = bus_event_i.scl_posedge & ninth_bit;
    rx_sample_o.data       = {shift_q, bus_event_i.sda};
    rx_sample_o.bit9       = bus_event_i.sda;
  end

endmodule

//--- bus_monitor.sv
// I3C bus monitor: synchronises SCL/SDA and reports edges and START, Sr and STOP
module bus_monitor
  import i3c_target_pkg::*;
#(
  parameter int unsigned SyncStages = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_i,
  input  logic       sda_i,
  output bus_event_t bus_event_o
);

  logic [SyncStages-1:0] scl_sync;
  logic [SyncStages-1:0] sda_sync;
  logic scl_s;
  logic sda_s;
  logic scl_q;
  logic sda_q;
  logic bus_open_q;

  logic scl_rise;
  logic scl_fall;
  logic sda_rise;
  logic sda_fall;
  logic scl_high;
  logic start_det;
  logic rstart_det;
  logic stop_det;

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync <= '1;
      sda_sync <= '1;
    end else begin
      scl_sync[0] <= scl_i;
      sda_sync[0] <= sda_i;
      for (int i = 1; i < SyncStages; i++) begin
        scl_sync[i] <= scl_sync[i-1];
        sda_sync[i] <= sda_sync[i-1];
      end
    end
  end

  assign scl_s = scl_sync[SyncStages-1];
  assign sda_s = sda_sync[SyncStages-1];

  assign scl_rise = scl_s & ~scl_q;
  assign scl_fall = ~scl_s & scl_q;
  assign sda_rise = sda_s & ~sda_q;
  assign sda_fall = ~sda_s & sda_q;
  assign scl_high = scl_s & scl_q;

  // SDA fall under high SCL opens a transfer, or restarts an open one
  assign start_det  = sda_fall & scl_high & ~bus_open_q;
  assign rstart_det = sda_fall & scl_high & bus_open_q;
  assign stop_det   = sda_rise & scl_high;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q       <= 1'b1;
      sda_q       <= 1'b1;
      bus_open_q  <= 1'b0;
      bus_event_o <= '{sda: 1'b1, default: 1'b0};
    end else begin
      scl_q <= scl_s;
      sda_q <= sda_s;
      if (start_det) begin
        bus_open_q <= 1'b1;
      end else if (stop_det) begin
        bus_open_q <= 1'b0;
      end
      bus_event_o.start       <= start_det;
      bus_event_o.rstart      <= rstart_det;
      bus_event_o.stop        <= stop_det;
      bus_event_o.scl_posedge <= scl_rise;
      bus_event_o.scl_negedge <= scl_fall;
      bus_event_o.sda         <= sda_s;
    end
  end

  // SCL and SDA moving in the same cycle could be neither a data bit nor a condition
  scl_sda_skew_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (scl_s != scl_q) |-> (sda_s == sda_q));

endmodule

//--- i3c_target_pkg.sv
// I3C target receive path: shared widths, descriptor layout, bus event and sample types
package i3c_target_pkg;

  // Bus and address widths
  localparam int unsigned AddrWidth = 7;
  localparam int unsigned DataWidth = 8;

  // RX descriptor layout
  localparam int unsigned DescWidth     = 32;
  localparam int unsigned DescCountLsb  = 0;
  localparam int unsigned DescCountMsb  = 15;
  localparam int unsigned DescAddrLsb   = 16;
  localparam int unsigned DescOvflBit   = 29;
  localparam int unsigned DescParityBit = 30;

  // One-cycle bus condition pulses plus the synchronised SDA level
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic scl_posedge;
    logic scl_negedge;
    logic sda;
  } bus_event_t;

  // Completed byte and ninth bit from the sampler
  typedef struct packed {
    logic                 byte_valid;
    logic                 bit9_valid;
    logic [DataWidth-1:0] data;
    logic                 bit9;
  } rx_sample_t;

  typedef enum logic [2:0] {
    Idle,
    Addr,
    Ack,
    Write,
    Skip
  } target_state_e;

endpackage
